// File: bench/pong_props.sv
`timescale 1ns/1ns

module pong_props import pong_pkg::*; (
    input logic   i_Clk,
    input logic   i_rst_n,
    input logic   i_frame_tick,
    input logic   i_left_point,
    input logic   i_right_point,
    input logic   i_hsync_n,
    input logic   i_vsync_n,
    input color_t i_color,
    input coord_t i_ball_x,
    input coord_t i_ball_y
);

    int fail_count = 0;

    strobes_apart: assert property (@(posedge i_Clk) disable iff (!i_rst_n)
        !(i_left_point && i_right_point))
        else begin
            $error("left and right point strobes high together");
            fail_count++;
        end

    tick_single: assert property (@(posedge i_Clk) disable iff (!i_rst_n)
        i_frame_tick |=> !i_frame_tick)
        else begin
            $error("frame tick longer than one cycle");
            fail_count++;
        end

    // sync pulses lie in blanking.
    dark_in_sync: assert property (@(posedge i_Clk) disable iff (!i_rst_n)
        (!i_hsync_n || !i_vsync_n) |-> (i_color == '0))
        else begin
            $error("colour not zero during a sync pulse");
            fail_count++;
        end

    ball_moves_on_tick: assert property (@(posedge i_Clk) disable iff (!i_rst_n)
        ((i_ball_x != $past(i_ball_x)) || (i_ball_y != $past(i_ball_y))) |-> $past(i_frame_tick))
        else begin
            $error("ball moved outside the cycle after a frame tick");
            fail_count++;
        end

endmodule

// File: bench/pong_tb.sv
`timescale 1ns/1ns
`include "pong_config.svh"

module pong_tb;

    localparam int H_ACTIVE = 64;
    localparam int H_FPORCH = 4;
    localparam int H_PULSE = 8;
    localparam int H_MAX = 80;
    localparam int V_ACTIVE = 48;
    localparam int V_FPORCH = 2;
    localparam int V_PULSE = 2;
    localparam int V_MAX = 53;
    localparam int CLK_PERIOD = 8;
    localparam int MAX_STEPS = 64;
    localparam int NONE = 1023; // object not seen in the frame.

    logic i_Clk;
    logic i_rst_n;
    logic i_switch_1;
    logic i_switch_2;
    logic i_switch_3;
    logic i_switch_4;
    logic o_vga_hsync_n;
    logic o_vga_vsync_n;
    logic [2:0] o_vga_red;
    logic [2:0] o_vga_grn;
    logic [2:0] o_vga_blu;
    logic [6:0] o_seg_left_n;
    logic [6:0] o_seg_right_n;

    int steps [MAX_STEPS][11]; // one trace line per entry.
    int num_steps;
    int total_frames;
    bit trace_loaded;
    int errors;
    int frames_done;
    int scan_col;
    int scan_row;
    int ball_x, ball_y, left_top, left_bot, right_top, right_bot;
    int seen_ball_x, seen_ball_y, seen_left_y, seen_right_y; // last finished frame.

    pong_top #(
        .H_ACTIVE    (H_ACTIVE),
        .H_FPORCH    (H_FPORCH),
        .H_PULSE     (H_PULSE),
        .H_MAX       (H_MAX),
        .V_ACTIVE    (V_ACTIVE),
        .V_FPORCH    (V_FPORCH),
        .V_PULSE     (V_PULSE),
        .V_MAX       (V_MAX),
        .PADDLE_HALF (6),
        .PADDLE_WIDTH(4),
        .BALL_HALF   (1)
    ) pong_top_inst (
        .i_Clk        (i_Clk),
        .i_rst_n      (i_rst_n),
        .i_switch_1   (i_switch_1),
        .i_switch_2   (i_switch_2),
        .i_switch_3   (i_switch_3),
        .i_switch_4   (i_switch_4),
        .o_vga_hsync_n(o_vga_hsync_n),
        .o_vga_vsync_n(o_vga_vsync_n),
        .o_vga_red    (o_vga_red),
        .o_vga_grn    (o_vga_grn),
        .o_vga_blu    (o_vga_blu),
        .o_seg_left_n (o_seg_left_n),
        .o_seg_right_n(o_seg_right_n)
    );

    bind pong_top pong_props pong_props_inst (
        .i_Clk        (i_Clk),
        .i_rst_n      (i_rst_n),
        .i_frame_tick (frame_tick),
        .i_left_point (left_point),
        .i_right_point(right_point),
        .i_hsync_n    (o_vga_hsync_n),
        .i_vsync_n    (o_vga_vsync_n),
        .i_color      ({o_vga_red, o_vga_grn, o_vga_blu}),
        .i_ball_x     (ball_x),
        .i_ball_y     (ball_y)
    );

    initial begin
        i_Clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_Clk = ~i_Clk;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("Error %s expected %0h got %0h", name, expected, actual);
        end
    endtask

    // active-low segments, a in bit 6.
    function automatic logic [6:0] digit_segments(input int digit);
        logic [6:0] seg;
        case (digit)
            0: seg = 7'h7E;
            1: seg = 7'h30;
            2: seg = 7'h6D;
            3: seg = 7'h79;
            4: seg = 7'h33;
            5: seg = 7'h5B;
            6: seg = 7'h5F;
            7: seg = 7'h70;
            8: seg = 7'h7F;
            9: seg = 7'h7B;
            default: seg = 7'h00;
        endcase
        return ~seg;
    endfunction

    task automatic load_trace();
        int fd;
        int code;
        string header;
        num_steps = 0;
        total_frames = 0;
        fd = $fopen("bench/pong_trace.txt", "r");
        if (fd != 0) begin
            code = $fgets(header, fd); // column names.
            while (code != 0 && num_steps < MAX_STEPS
                   && $fscanf(fd, "%d %d %d %d %d %d %d %d %d %d %d",
                   steps[num_steps][0], steps[num_steps][1], steps[num_steps][2],
                   steps[num_steps][3], steps[num_steps][4], steps[num_steps][5],
                   steps[num_steps][6], steps[num_steps][7], steps[num_steps][8],
                   steps[num_steps][9], steps[num_steps][10]) == 11) begin
                total_frames += steps[num_steps][0];
                num_steps++;
            end
            $fclose(fd);
        end
        trace_loaded = (num_steps > 0);
    endtask

    // outputs at a negedge show the pixel the counters held one cycle earlier.
    task automatic scan_pixel();
        logic [8:0] color;
        color = {o_vga_red, o_vga_grn, o_vga_blu};
        check_value("o_vga_hsync_n", o_vga_hsync_n, !(scan_col >= H_ACTIVE + H_FPORCH
                    && scan_col < H_ACTIVE + H_FPORCH + H_PULSE));
        check_value("o_vga_vsync_n", o_vga_vsync_n, !(scan_row >= V_ACTIVE + V_FPORCH
                    && scan_row < V_ACTIVE + V_FPORCH + V_PULSE));
        if (scan_col == 0 && scan_row == 0) begin
            ball_x = NONE;
            ball_y = NONE;
            left_top = NONE;
            left_bot = NONE;
            right_top = NONE;
            right_bot = NONE;
        end
        if (scan_col < H_ACTIVE && scan_row < V_ACTIVE) begin
            if (color == `PONG_COLOR_BALL) begin
                ball_x = scan_col;
                ball_y = scan_row;
            end
            if (color == `PONG_COLOR_LEFT) begin
                left_top = (left_top == NONE) ? scan_row : left_top;
                left_bot = scan_row;
            end
            if (color == `PONG_COLOR_RIGHT) begin
                right_top = (right_top == NONE) ? scan_row : right_top;
                right_bot = scan_row;
            end
        end else begin
            check_value("color", color, 0); // blanking.
        end
        if (scan_col == H_ACTIVE - 1 && scan_row == V_ACTIVE - 1) begin
            seen_ball_x = ball_x;
            seen_ball_y = ball_y;
            seen_left_y = (left_top + left_bot) / 2;
            seen_right_y = (right_top + right_bot) / 2;
            frames_done++;
        end
        if (scan_col == H_MAX - 1) begin
            scan_col = 0;
            scan_row = (scan_row == V_MAX - 1) ? 0 : scan_row + 1;
        end else begin
            scan_col++;
        end
    endtask

    initial begin
        scan_col = 0;
        scan_row = 0;
        frames_done = 0;
        @(posedge i_rst_n);
        @(posedge i_Clk); // pixel (0, 0) is registered here.
        forever begin
            @(negedge i_Clk);
            scan_pixel();
        end
    end

    // switches change in blanking, before the next frame tick.
    task automatic run_step(input int s);
        int target;
        target = frames_done + steps[s][0];
        @(posedge i_Clk);
        #1;
        i_switch_1 = (steps[s][1] != 0);
        i_switch_2 = (steps[s][2] != 0);
        i_switch_3 = (steps[s][3] != 0);
        i_switch_4 = (steps[s][4] != 0);
        wait (frames_done >= target);
        check_value("o_seg_left_n", o_seg_left_n, digit_segments(steps[s][5]));
        check_value("o_seg_right_n", o_seg_right_n, digit_segments(steps[s][6]));
        check_value("ball_y", seen_ball_y, steps[s][7]);
        check_value("ball_x", seen_ball_x, steps[s][8]);
        check_value("left_y", seen_left_y, steps[s][9]);
        check_value("right_y", seen_right_y, steps[s][10]);
    endtask

    initial begin : main_flow
        int assert_fails;
        i_rst_n = 1'b0;
        i_switch_1 = 1'b0;
        i_switch_2 = 1'b0;
        i_switch_3 = 1'b0;
        i_switch_4 = 1'b0;
        errors = 0;
        load_trace();
        if (!trace_loaded) begin
            $display("could not read any step from bench/pong_trace.txt");
            $display("Result: FAILED");
            $finish;
        end else begin
            repeat (3) @(posedge i_Clk);
            #1;
            i_rst_n = 1'b1;
            for (int s = 0; s < num_steps; s++) begin
                run_step(s);
            end
            assert_fails = pong_top_inst.pong_props_inst.fail_count;
            $display("check errors %0d, assertion failures %0d", errors, assert_fails);
            if (errors == 0 && assert_fails == 0) begin
                $display("Result: PASSED");
            end else begin
                $display("Result: FAILED");
            end
            $finish;
        end
    end

    initial begin : watchdog
        int limit_ns;
        wait (trace_loaded);
        limit_ns = (total_frames + 3) * H_MAX * V_MAX * CLK_PERIOD; // three frames spare.
        #(limit_ns);
        $display("timeout, the trace did not finish within %0d ns", limit_ns);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// File: bench/pong_trace.txt
# frames sw1 sw2 sw3 sw4 score_left score_right ball_row ball_col left_row right_row
1 0 0 0 0 0 0 24 32 24 24
40 0 0 0 1 0 0 24 32 24 42
24 1 0 0 0 0 0 47 55 6 42
13 1 0 0 0 0 0 34 58 6 42
34 1 0 0 0 0 0 0 24 6 42
20 0 0 0 0 0 0 20 4 6 42
5 0 0 0 0 0 1 24 32 6 42
24 0 1 0 0 0 1 24 32 30 42
1 1 0 0 0 0 1 24 32 29 42
33 0 0 0 0 0 2 24 32 29 42
1 1 0 0 0 0 2 24 32 28 42
33 0 0 0 0 0 3 24 32 28 42
1 1 0 0 0 0 3 24 32 27 42
33 0 0 0 0 0 4 24 32 27 42
1 1 0 0 0 0 4 24 32 26 42
33 0 0 0 0 0 5 24 32 26 42
1 1 0 0 0 0 5 24 32 25 42
33 0 0 0 0 0 6 24 32 25 42
1 1 0 0 0 0 6 24 32 24 42
33 0 0 0 0 0 7 24 32 24 42
1 1 0 0 0 0 7 24 32 23 42
33 0 0 0 0 0 8 24 32 23 42
1 1 0 0 0 0 8 24 32 22 42
33 0 0 0 0 0 9 24 32 22 42
1 1 0 0 0 0 9 24 32 21 42
33 0 0 0 0 0 0 24 32 21 42

// File: include/pong_config.svh
`ifndef PONG_CONFIG_SVH
`define PONG_CONFIG_SVH

// horizontal timing in pixel clocks.
`define PONG_H_ACTIVE 640
`define PONG_H_FPORCH 16
`define PONG_H_PULSE 96
`define PONG_H_MAX 800

// vertical timing in lines.
`define PONG_V_ACTIVE 480
`define PONG_V_FPORCH 10
`define PONG_V_PULSE 2
`define PONG_V_MAX 525

`define PONG_PADDLE_HALF 30     // half of the paddle height.
`define PONG_PADDLE_WIDTH 10
`define PONG_BALL_HALF 3

// rrr_ggg_bbb.
`define PONG_COLOR_BALL 9'b000_111_000  // green.
`define PONG_COLOR_LEFT 9'b111_111_000  // yellow.
`define PONG_COLOR_RIGHT 9'b000_111_111 // cyan.

`endif

// File: verilog.f
+incdir+include
verilog/pong_pkg.sv
verilog/vga_timing.sv
verilog/pong_game.sv
verilog/pong_render.sv
verilog/score_display.sv
verilog/pong_top.sv
bench/pong_props.sv
bench/pong_tb.sv

// File: verilog/pong_game.sv
`timescale 1ns/1ns
`include "pong_config.svh"

module pong_game import pong_pkg::*; #(
    parameter int H_ACTIVE    = `PONG_H_ACTIVE,
    parameter int V_ACTIVE    = `PONG_V_ACTIVE,
    parameter int PADDLE_HALF = `PONG_PADDLE_HALF
) (
    input  logic   i_Clk,
    input  logic   i_rst_n,
    input  logic   i_frame_tick,
    input  logic   i_switch_1,
    input  logic   i_switch_2,
    input  logic   i_switch_3,
    input  logic   i_switch_4,
    output coord_t o_ball_x,
    output coord_t o_ball_y,
    output coord_t o_left_y,
    output coord_t o_right_y,
    output logic   o_left_point,
    output logic   o_right_point
);

    localparam coord_t X_CENTRE   = coord_t'(H_ACTIVE / 2);
    localparam coord_t Y_CENTRE   = coord_t'(V_ACTIVE / 2);
    localparam coord_t X_LAST     = coord_t'(H_ACTIVE - 1);
    localparam coord_t Y_LAST     = coord_t'(V_ACTIVE - 1);
    localparam coord_t PAD_TOP    = coord_t'(PADDLE_HALF);
    localparam coord_t PAD_BOTTOM = coord_t'(V_ACTIVE - PADDLE_HALF);

    game_state_e state;
    coord_t ball_x;
    coord_t ball_y;
    coord_t left_y;
    coord_t right_y;
    logic dx_neg; // 1 when moving left.
    logic dy_neg; // 1 when moving up.

    logic at_left;
    logic at_right;
    logic left_cover;
    logic right_cover;
    logic dx_neg_next;
    logic dy_neg_next;

    // one step of a paddle, clamped to keep it fully on screen.
    function automatic coord_t paddle_step(input coord_t y, input logic up, input logic down);
        coord_t y_next;
        y_next = y;
        if (up && (y > PAD_TOP)) begin
            y_next = y - 1'b1;
        end
        if (down && (y < PAD_BOTTOM)) begin
            y_next = y + 1'b1;
        end
        return y_next;
    endfunction

    assign at_right = (ball_x == X_LAST) && !dx_neg;
    assign at_left = (ball_x == '0) && dx_neg;
    assign right_cover = coord_dist(ball_y, right_y) < PAD_TOP;
    assign left_cover = coord_dist(ball_y, left_y) < PAD_TOP;

    always_comb begin
        dx_neg_next = dx_neg;
        dy_neg_next = dy_neg;
        if (at_right) begin
            dx_neg_next = 1'b1;
        end else if (at_left) begin
            dx_neg_next = 1'b0;
        end
        if (ball_y == '0) begin
            dy_neg_next = 1'b0; // top wall.
        end else if (ball_y == Y_LAST) begin
            dy_neg_next = 1'b1;
        end
    end

    always_ff @(posedge i_Clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= IDLE;
            ball_x <= X_CENTRE;
            ball_y <= Y_CENTRE;
            left_y <= Y_CENTRE;
            right_y <= Y_CENTRE;
            dx_neg <= 1'b0;
            dy_neg <= 1'b0;
            o_left_point <= 1'b0;
            o_right_point <= 1'b0;
        end else begin
            o_left_point <= 1'b0;
            o_right_point <= 1'b0;
            if (i_frame_tick) begin
                if (state == IDLE) begin
                    ball_x <= X_CENTRE;
                    ball_y <= Y_CENTRE;
                    if (i_switch_1) begin
                        state <= PLAY; // serve.
                    end
                end else if (at_right && !right_cover) begin
                    state <= IDLE;
                    ball_x <= X_CENTRE;
                    ball_y <= Y_CENTRE;
                    o_left_point <= 1'b1;
                end else if (at_left && !left_cover) begin
                    state <= IDLE;
                    ball_x <= X_CENTRE;
                    ball_y <= Y_CENTRE;
                    o_right_point <= 1'b1;
                end else begin
                    dx_neg <= dx_neg_next;
                    dy_neg <= dy_neg_next;
                    ball_x <= dx_neg_next ? ball_x - 1'b1 : ball_x + 1'b1;
                    ball_y <= dy_neg_next ? ball_y - 1'b1 : ball_y + 1'b1;
                end
                left_y <= paddle_step(left_y, i_switch_1, i_switch_2);
                right_y <= paddle_step(right_y, i_switch_3, i_switch_4);
            end
        end
    end

    assign o_ball_x = ball_x;
    assign o_ball_y = ball_y;
    assign o_left_y = left_y;
    assign o_right_y = right_y;

endmodule

// File: verilog/pong_pkg.sv
package pong_pkg;

    typedef logic [9:0] coord_t; // column, row or object centre.
    typedef logic [8:0] color_t; // red in [8:6], green in [5:3], blue in [2:0].

    typedef enum logic {
        IDLE, // ball parked at the centre.
        PLAY
    } game_state_e;

    // unsigned distance between two coordinates.
    function automatic coord_t coord_dist(input coord_t a, input coord_t b);
        coord_t d;
        if (a > b) begin
            d = a - b;
        end else begin
            d = b - a;
        end
        return d;
    endfunction

endpackage

// File: verilog/pong_render.sv
`timescale 1ns/1ns
`include "pong_config.svh"

module pong_render import pong_pkg::*; #(
    parameter int H_ACTIVE     = `PONG_H_ACTIVE,
    parameter int PADDLE_HALF  = `PONG_PADDLE_HALF,
    parameter int PADDLE_WIDTH = `PONG_PADDLE_WIDTH,
    parameter int BALL_HALF    = `PONG_BALL_HALF
) (
    input  logic   i_Clk,
    input  logic   i_rst_n,
    input  coord_t i_column,
    input  coord_t i_row,
    input  logic   i_active,
    input  logic   i_hsync_n,
    input  logic   i_vsync_n,
    input  coord_t i_ball_x,
    input  coord_t i_ball_y,
    input  coord_t i_left_y,
    input  coord_t i_right_y,
    output color_t o_color,
    output logic   o_hsync_n,
    output logic   o_vsync_n
);

    localparam coord_t PAD_HALF   = coord_t'(PADDLE_HALF);
    localparam coord_t BALL_SIZE  = coord_t'(BALL_HALF);
    localparam coord_t LEFT_EDGE  = coord_t'(PADDLE_WIDTH);
    localparam coord_t RIGHT_EDGE = coord_t'(H_ACTIVE - PADDLE_WIDTH);

    logic ball_hit;
    logic left_hit;
    logic right_hit;
    color_t color_next;

    assign ball_hit = (coord_dist(i_column, i_ball_x) < BALL_SIZE)
                   && (coord_dist(i_row, i_ball_y) < BALL_SIZE);
    assign left_hit = (i_column < LEFT_EDGE) && (coord_dist(i_row, i_left_y) < PAD_HALF);
    assign right_hit = (i_column >= RIGHT_EDGE) && (coord_dist(i_row, i_right_y) < PAD_HALF);

    // paddles draw over the ball.
    always_comb begin
        color_next = '0;
        if (i_active) begin
            if (right_hit) begin
                color_next = `PONG_COLOR_RIGHT;
            end else if (left_hit) begin
                color_next = `PONG_COLOR_LEFT;
            end else if (ball_hit) begin
                color_next = `PONG_COLOR_BALL;
            end
        end
    end

    // syncs go through the same stage so they stay aligned with colour.
    always_ff @(posedge i_Clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_color <= '0;
            o_hsync_n <= 1'b1;
            o_vsync_n <= 1'b1;
        end else begin
            o_color <= color_next;
            o_hsync_n <= i_hsync_n;
            o_vsync_n <= i_vsync_n;
        end
    end

endmodule

// File: verilog/pong_top.sv
`timescale 1ns/1ns
`include "pong_config.svh"

module pong_top import pong_pkg::*; #(
    parameter int H_ACTIVE     = `PONG_H_ACTIVE,
    parameter int H_FPORCH     = `PONG_H_FPORCH,
    parameter int H_PULSE      = `PONG_H_PULSE,
    parameter int H_MAX        = `PONG_H_MAX,
    parameter int V_ACTIVE     = `PONG_V_ACTIVE,
    parameter int V_FPORCH     = `PONG_V_FPORCH,
    parameter int V_PULSE      = `PONG_V_PULSE,
    parameter int V_MAX        = `PONG_V_MAX,
    parameter int PADDLE_HALF  = `PONG_PADDLE_HALF,
    parameter int PADDLE_WIDTH = `PONG_PADDLE_WIDTH,
    parameter int BALL_HALF    = `PONG_BALL_HALF
) (
    input  logic       i_Clk,
    input  logic       i_rst_n,
    input  logic       i_switch_1,
    input  logic       i_switch_2,
    input  logic       i_switch_3,
    input  logic       i_switch_4,
    output logic       o_vga_hsync_n,
    output logic       o_vga_vsync_n,
    output logic [2:0] o_vga_red,
    output logic [2:0] o_vga_grn,
    output logic [2:0] o_vga_blu,
    output logic [6:0] o_seg_left_n,
    output logic [6:0] o_seg_right_n
);

    coord_t column;
    coord_t row;
    logic active;
    logic hsync_n;
    logic vsync_n;
    logic frame_tick;
    coord_t ball_x;
    coord_t ball_y;
    coord_t left_y;
    coord_t right_y;
    logic left_point;
    logic right_point;

    vga_timing #(
        .H_ACTIVE(H_ACTIVE),
        .H_FPORCH(H_FPORCH),
        .H_PULSE (H_PULSE),
        .H_MAX   (H_MAX),
        .V_ACTIVE(V_ACTIVE),
        .V_FPORCH(V_FPORCH),
        .V_PULSE (V_PULSE),
        .V_MAX   (V_MAX)
    ) vga_timing_inst (
        .i_Clk       (i_Clk),
        .i_rst_n     (i_rst_n),
        .o_column    (column),
        .o_row       (row),
        .o_active    (active),
        .o_hsync_n   (hsync_n),
        .o_vsync_n   (vsync_n),
        .o_frame_tick(frame_tick)
    );

    pong_game #(
        .H_ACTIVE   (H_ACTIVE),
        .V_ACTIVE   (V_ACTIVE),
        .PADDLE_HALF(PADDLE_HALF)
    ) pong_game_inst (
        .i_Clk        (i_Clk),
        .i_rst_n      (i_rst_n),
        .i_frame_tick (frame_tick),
        .i_switch_1   (i_switch_1),
        .i_switch_2   (i_switch_2),
        .i_switch_3   (i_switch_3),
        .i_switch_4   (i_switch_4),
        .o_ball_x     (ball_x),
        .o_ball_y     (ball_y),
        .o_left_y     (left_y),
        .o_right_y    (right_y),
        .o_left_point (left_point),
        .o_right_point(right_point)
    );

    pong_render #(
        .H_ACTIVE    (H_ACTIVE),
        .PADDLE_HALF (PADDLE_HALF),
        .PADDLE_WIDTH(PADDLE_WIDTH),
        .BALL_HALF   (BALL_HALF)
    ) pong_render_inst (
        .i_Clk    (i_Clk),
        .i_rst_n  (i_rst_n),
        .i_column (column),
        .i_row    (row),
        .i_active (active),
        .i_hsync_n(hsync_n),
        .i_vsync_n(vsync_n),
        .i_ball_x (ball_x),
        .i_ball_y (ball_y),
        .i_left_y (left_y),
        .i_right_y(right_y),
        .o_color  ({o_vga_red, o_vga_grn, o_vga_blu}),
        .o_hsync_n(o_vga_hsync_n),
        .o_vsync_n(o_vga_vsync_n)
    );

    score_display score_display_inst (
        .i_Clk        (i_Clk),
        .i_rst_n      (i_rst_n),
        .i_left_point (left_point),
        .i_right_point(right_point),
        .o_seg_left_n (o_seg_left_n),
        .o_seg_right_n(o_seg_right_n)
    );

endmodule

// File: verilog/score_display.sv
`timescale 1ns/1ns

module score_display (
    input  logic       i_Clk,
    input  logic       i_rst_n,
    input  logic       i_left_point,
    input  logic       i_right_point,
    output logic [6:0] o_seg_left_n,
    output logic [6:0] o_seg_right_n
);

    logic [1:0] point;
    logic [3:0] score [2]; // index 0 is the left player.
    logic [6:0] seg_n [2];

    // segment a in bit 6, active high.
    function automatic logic [6:0] seg_decode(input logic [3:0] value);
        logic [6:0] seg;
        case (value)
            4'h0: seg = 7'h7E;
            4'h1: seg = 7'h30;
            4'h2: seg = 7'h6D;
            4'h3: seg = 7'h79;
            4'h4: seg = 7'h33;
            4'h5: seg = 7'h5B;
            4'h6: seg = 7'h5F;
            4'h7: seg = 7'h70;
            4'h8: seg = 7'h7F;
            4'h9: seg = 7'h7B;
            4'hA: seg = 7'h77;
            4'hB: seg = 7'h1F;
            4'hC: seg = 7'h4E;
            4'hD: seg = 7'h3D;
            4'hE: seg = 7'h4F;
            default: seg = 7'h47;
        endcase
        return seg;
    endfunction

    assign point = {i_right_point, i_left_point};

    always_ff @(posedge i_Clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int p = 0; p < 2; p++) begin
                score[p] <= '0;
                seg_n[p] <= ~7'h7E; // digit 0.
            end
        end else begin
            for (int p = 0; p < 2; p++) begin
                if (point[p]) begin
                    score[p] <= (score[p] == 4'd9) ? 4'd0 : score[p] + 1'b1;
                end
                seg_n[p] <= ~seg_decode(score[p]);
            end
        end
    end

    assign o_seg_left_n = seg_n[0];
    assign o_seg_right_n = seg_n[1];

endmodule

// File: verilog/vga_timing.sv
`timescale 1ns/1ns
`include "pong_config.svh"

module vga_timing import pong_pkg::*; #(
    parameter int H_ACTIVE = `PONG_H_ACTIVE,
    parameter int H_FPORCH = `PONG_H_FPORCH,
    parameter int H_PULSE  = `PONG_H_PULSE,
    parameter int H_MAX    = `PONG_H_MAX,
    parameter int V_ACTIVE = `PONG_V_ACTIVE,
    parameter int V_FPORCH = `PONG_V_FPORCH,
    parameter int V_PULSE  = `PONG_V_PULSE,
    parameter int V_MAX    = `PONG_V_MAX
) (
    input  logic   i_Clk,
    input  logic   i_rst_n,
    output coord_t o_column,
    output coord_t o_row,
    output logic   o_active,
    output logic   o_hsync_n,
    output logic   o_vsync_n,
    output logic   o_frame_tick
);

    localparam coord_t COL_LAST = coord_t'(H_MAX - 1);
    localparam coord_t ROW_LAST = coord_t'(V_MAX - 1);
    localparam coord_t HS_START = coord_t'(H_ACTIVE + H_FPORCH);
    localparam coord_t HS_END   = coord_t'(H_ACTIVE + H_FPORCH + H_PULSE);
    localparam coord_t VS_START = coord_t'(V_ACTIVE + V_FPORCH);
    localparam coord_t VS_END   = coord_t'(V_ACTIVE + V_FPORCH + V_PULSE);

    coord_t column;
    coord_t row;

    always_ff @(posedge i_Clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            column <= '0;
            row <= '0;
        end else if (column == COL_LAST) begin
            column <= '0;
            if (row == ROW_LAST) begin
                row <= '0;
            end else begin
                row <= row + 1'b1;
            end
        end else begin
            column <= column + 1'b1;
        end
    end

    assign o_column = column;
    assign o_row = row;
    assign o_active = (column < coord_t'(H_ACTIVE)) && (row < coord_t'(V_ACTIVE));

    // sync pulses sit after the front porch.
    assign o_hsync_n = !((column >= HS_START) && (column < HS_END));
    assign o_vsync_n = !((row >= VS_START) && (row < VS_END));

    assign o_frame_tick = (row == coord_t'(V_ACTIVE)) && (column == '0); // first blank line.

endmodule
